/* verilog/cache_pkg.sv */
package cache_pkg;

    // address split is tag | index | offset, 32 bits in all
    localparam int tag_w    = 20;
    localparam int index_w  = 8;
    localparam int offset_w = 4;   // 16-byte line

    localparam int num_sets  = 256;
    localparam int num_ways  = 2;
    localparam int num_banks = 4;  // one 32-bit word per bank

    // controller states, one-hot
    // idle     waiting for a CPU request
    // lookup   tag compare and hit return
    // miss     dirty victim being written back
    // replace  line read request to memory
    // refill   collecting the four return beats
    typedef enum logic [4:0] {
        idle    = 5'b00001,
        lookup  = 5'b00010,
        miss    = 5'b00100,
        replace = 5'b01000,
        refill  = 5'b10000
    } cache_state_t;

endpackage

/* verilog/cache_sram.sv */
`timescale 1ns/10ps

module cache_sram #(
    parameter int width = 32,
    parameter int depth = 256,
    parameter int lanes = 4
) (
    input  logic                     clk,
    input  logic [lanes-1:0]         we,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic [width-1:0]         wdata,
    output logic [width-1:0]         rdata
);

    localparam int lane_w = width / lanes;

    logic [width-1:0] mem [depth];

    // read-first, so a write cycle returns the old word
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
        for (int l = 0; l < lanes; l++) begin
            if (we[l]) begin
                mem[addr][l*lane_w +: lane_w] <= wdata[l*lane_w +: lane_w];
            end
        end
    end

endmodule

/* verilog/cache_store_buffer.sv */
`timescale 1ns/10ps

module cache_store_buffer import cache_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    // store hit from lookup
    input  logic                         sb_push,
    input  logic                         sb_way,
    input  logic [index_w-1:0]           sb_index,
    input  logic [offset_w-1:0]          sb_offset,
    input  logic [3:0]                   sb_wstrb,
    input  logic [31:0]                  sb_wdata,
    // request on the CPU port, for the bank conflict check
    input  logic                         req_valid,
    input  logic                         req_op,
    input  logic [offset_w-1:0]          req_offset,
    // pending write into the data banks
    output logic                         sb_write,
    output logic                         sb_way_q,
    output logic [$clog2(num_banks)-1:0] sb_bank_q,
    output logic [index_w-1:0]           sb_index_q,
    output logic [3:0]                   sb_wstrb_q,
    output logic [31:0]                  sb_wdata_q,
    output logic                         sb_hazard
);

    localparam int bank_w = $clog2(num_banks);

    // pending flag, stays up over back-to-back pushes
    always_ff @(posedge clk) begin
        if (rst) begin
            sb_write <= 1'b0;
        end else begin
            sb_write <= sb_push;
        end
    end

    always_ff @(posedge clk) begin
        if (sb_push) begin
            sb_way_q   <= sb_way;
            sb_bank_q  <= sb_offset[offset_w-1 -: bank_w];  // word select only
            sb_index_q <= sb_index;
            sb_wstrb_q <= sb_wstrb;
            sb_wdata_q <= sb_wdata;
        end
    end

    // bank port is busy with the write, so a load to it waits a cycle
    assign sb_hazard = sb_write && req_valid && !req_op
                    && req_offset[offset_w-1 -: bank_w] == sb_bank_q;

endmodule

/* verilog/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl import cache_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst,
    // CPU port
    input  logic                                    valid,
    input  logic                                    op,
    input  logic [index_w-1:0]                      index,
    input  logic [tag_w-1:0]                        tag,
    input  logic [offset_w-1:0]                     offset,
    input  logic [3:0]                              wstrb,
    input  logic [31:0]                             wdata,
    output logic                                    addr_ok,
    output logic                                    data_ok,
    output logic [31:0]                             rdata,
    // memory read channel
    output logic                                    rd_req,
    output logic [31:0]                             rd_addr,
    input  logic                                    rd_rdy,
    input  logic                                    ret_valid,
    input  logic                                    ret_last,
    input  logic [31:0]                             ret_data,
    // memory write channel
    output logic                                    wr_req,
    output logic [31:0]                             wr_addr,
    output logic [num_banks*32-1:0]                 wr_data,
    input  logic                                    wr_rdy,
    // tag RAMs
    output logic [num_ways-1:0]                     tag_we,
    output logic [index_w-1:0]                      tag_addr,
    output logic [tag_w-1:0]                        tag_wdata,
    input  logic [num_ways-1:0][tag_w-1:0]          tag_rdata,
    // data banks
    output logic [num_ways-1:0][num_banks-1:0][3:0] bank_we,
    output logic [num_ways-1:0][num_banks-1:0][index_w-1:0] bank_addr,
    output logic [num_ways-1:0][num_banks-1:0][31:0] bank_wdata,
    input  logic [num_ways-1:0][num_banks-1:0][31:0] bank_rdata,
    // store buffer
    output logic                                    sb_push,
    output logic                                    sb_way,
    output logic [index_w-1:0]                      sb_index,
    output logic [offset_w-1:0]                     sb_offset,
    output logic [3:0]                              sb_wstrb,
    output logic [31:0]                             sb_wdata,
    input  logic                                    sb_write,
    input  logic                                    sb_way_q,
    input  logic [$clog2(num_banks)-1:0]            sb_bank_q,
    input  logic [index_w-1:0]                      sb_index_q,
    input  logic [3:0]                              sb_wstrb_q,
    input  logic [31:0]                             sb_wdata_q,
    input  logic                                    sb_hazard
);

    localparam int bank_w = $clog2(num_banks);

    cache_state_t state, state_nx;

    logic                            req_op;
    logic [index_w-1:0]              req_index;
    logic [tag_w-1:0]                req_tag;
    logic [offset_w-1:0]             req_offset;
    logic [3:0]                      req_wstrb;
    logic [31:0]                     req_wdata;
    logic [bank_w-1:0]               req_bank;
    logic [num_ways-1:0][num_sets-1:0] valid_arr;
    logic [num_ways-1:0][num_sets-1:0] dirty_arr;
    logic [num_ways-1:0]             way_hit;
    logic                            cache_hit;
    logic                            st_conflict;
    logic                            victim_dirty;
    logic [2:0]                      lfsr;
    logic                            victim;
    logic [bank_w-1:0]               ret_cnt;
    logic [31:0]                     refill_word;
    logic                            front;      // idle or lookup, banks follow the CPU index

    assign req_bank = req_offset[offset_w-1 -: bank_w];
    assign victim   = lfsr[0];
    assign front    = (state == idle) || (state == lookup);

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = valid_arr[w][req_index] && tag_rdata[w] == req_tag;
        end
    end
    assign cache_hit = |way_hit;

    // load right behind a store hit to the same word
    assign st_conflict = (state == lookup) && cache_hit && req_op && valid && !op
                      && index == req_index && offset == req_offset;

    // a store still in the buffer counts as dirty
    assign victim_dirty = valid_arr[victim][req_index]
                       && (dirty_arr[victim][req_index]
                           || (sb_write && sb_way_q == victim && sb_index_q == req_index));

    assign addr_ok = valid && !st_conflict && !sb_hazard
                  && (state == idle || (state == lookup && cache_hit));
    assign data_ok = (state == lookup && (cache_hit || req_op))
                  || (state == refill && ret_valid && !req_op && ret_cnt == req_bank);
    assign rdata   = (state == refill) ? ret_data : bank_rdata[way_hit[1]][req_bank];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        unique case (state)
            idle:    if (valid && addr_ok) state_nx = lookup;
            lookup: begin
                if (cache_hit) begin
                    state_nx = addr_ok ? lookup : idle;
                end else begin
                    state_nx = victim_dirty ? miss : replace;
                end
            end
            miss:    if (wr_req && wr_rdy) state_nx = replace;
            replace: if (rd_rdy) state_nx = refill;
            refill:  if (ret_valid && ret_last) state_nx = idle;
            default: state_nx = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req_op     <= op;
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else begin
            if (sb_write) begin
                dirty_arr[sb_way_q][sb_index_q] <= 1'b1;
            end
            if (state == refill && ret_valid && ret_last) begin
                valid_arr[victim][req_index] <= 1'b1;
                dirty_arr[victim][req_index] <= req_op;  // store miss leaves it dirty
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr    <= 3'b111;
            ret_cnt <= '0;
        end else if (ret_valid) begin
            ret_cnt <= ret_last ? '0 : ret_cnt + 1'b1;
            if (ret_last) begin
                lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
            end
        end
    end

    // victim banks need a clean read of req_index before the line goes out
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_req <= 1'b0;
        end else if (wr_req && wr_rdy) begin
            wr_req <= 1'b0;
        end else if (state == miss) begin
            wr_req <= 1'b1;
        end
    end

    assign wr_addr = {tag_rdata[victim], req_index, {offset_w{1'b0}}};
    assign wr_data = bank_rdata[victim];
    assign rd_req  = (state == replace);
    assign rd_addr = {req_tag, req_index, {offset_w{1'b0}}};

    assign sb_push   = (state == lookup) && cache_hit && req_op;
    assign sb_way    = way_hit[1];
    assign sb_index  = req_index;
    assign sb_offset = req_offset;
    assign sb_wstrb  = req_wstrb;
    assign sb_wdata  = req_wdata;

    // store-miss bytes land on their beat
    always_comb begin
        refill_word = ret_data;
        if (req_op && ret_cnt == req_bank) begin
            for (int i = 0; i < 4; i++) begin
                if (req_wstrb[i]) begin
                    refill_word[8*i +: 8] = req_wdata[8*i +: 8];
                end
            end
        end
    end

    assign tag_addr  = front ? index : req_index;
    assign tag_wdata = req_tag;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        assign tag_we[w] = (state == refill) && ret_valid && ret_last && victim == w;
        for (genvar b = 0; b < num_banks; b++) begin : g_bank
            logic sb_sel;
            logic fill_sel;
            assign sb_sel   = sb_write && sb_way_q == w && sb_bank_q == bank_w'(b);
            assign fill_sel = (state == refill) && ret_valid && victim == w
                           && ret_cnt == bank_w'(b);
            assign bank_we[w][b]    = sb_sel ? sb_wstrb_q : (fill_sel ? 4'hf : 4'h0);
            assign bank_wdata[w][b] = sb_sel ? sb_wdata_q : refill_word;
            assign bank_addr[w][b]  = sb_sel ? sb_index_q : (front ? index : req_index);
        end
    end

endmodule

/* verilog/cache_top.sv */
`timescale 1ns/10ps

module cache_top import cache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // CPU port
    input  logic                    valid,
    input  logic                    op,
    input  logic [index_w-1:0]      index,
    input  logic [tag_w-1:0]        tag,
    input  logic [offset_w-1:0]     offset,
    input  logic [3:0]              wstrb,
    input  logic [31:0]             wdata,
    output logic                    addr_ok,
    output logic                    data_ok,
    output logic [31:0]             rdata,
    // memory read channel
    output logic                    rd_req,
    output logic [31:0]             rd_addr,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  logic [31:0]             ret_data,
    // memory write channel
    output logic                    wr_req,
    output logic [31:0]             wr_addr,
    output logic [num_banks*32-1:0] wr_data,
    input  logic                    wr_rdy
);

    logic [num_ways-1:0]                             tag_we;
    logic [index_w-1:0]                              tag_addr;
    logic [tag_w-1:0]                                tag_wdata;
    logic [num_ways-1:0][tag_w-1:0]                  tag_rdata;
    logic [num_ways-1:0][num_banks-1:0][3:0]         bank_we;
    logic [num_ways-1:0][num_banks-1:0][index_w-1:0] bank_addr;
    logic [num_ways-1:0][num_banks-1:0][31:0]        bank_wdata;
    logic [num_ways-1:0][num_banks-1:0][31:0]        bank_rdata;

    logic                         sb_push;
    logic                         sb_way;
    logic [index_w-1:0]           sb_index;
    logic [offset_w-1:0]          sb_offset;
    logic [3:0]                   sb_wstrb;
    logic [31:0]                  sb_wdata;
    logic                         sb_write;
    logic                         sb_way_q;
    logic [$clog2(num_banks)-1:0] sb_bank_q;
    logic [index_w-1:0]           sb_index_q;
    logic [3:0]                   sb_wstrb_q;
    logic [31:0]                  sb_wdata_q;
    logic                         sb_hazard;

    cache_ctrl ctrl_i (.*);

    cache_store_buffer sb_i (
        .clk, .rst,
        .sb_push, .sb_way, .sb_index, .sb_offset, .sb_wstrb, .sb_wdata,
        .req_valid  (valid),
        .req_op     (op),
        .req_offset (offset),
        .sb_write, .sb_way_q, .sb_bank_q, .sb_index_q, .sb_wstrb_q, .sb_wdata_q,
        .sb_hazard
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        cache_sram #(.width(tag_w), .depth(num_sets), .lanes(1)) tag_ram_i (
            .clk, .we(tag_we[w]), .addr(tag_addr), .wdata(tag_wdata), .rdata(tag_rdata[w])
        );
        for (genvar b = 0; b < num_banks; b++) begin : g_bank
            cache_sram #(.width(32), .depth(num_sets), .lanes(4)) data_ram_i (
                .clk,
                .we    (bank_we[w][b]),     // byte lanes
                .addr  (bank_addr[w][b]),
                .wdata (bank_wdata[w][b]),
                .rdata (bank_rdata[w][b])
            );
        end
    end

endmodule

/* test/cache_props.sv */
`timescale 1ns/10ps

module cache_props import cache_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         rd_req,
    input logic [31:0]  rd_addr,
    input logic         rd_rdy,
    input logic         wr_req,
    input logic [31:0]  wr_addr,
    input logic         wr_rdy,
    input logic         data_ok,
    input cache_state_t state
);

    int fail_count;   // summed into the final report

    // request held with a steady address until the bridge takes it
    rd_hold: assert property (@(posedge clk) disable iff (rst)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            fail_count++;
            $error("rd_req dropped or rd_addr changed before rd_rdy");
        end

    wr_hold: assert property (@(posedge clk) disable iff (rst)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
        else begin
            fail_count++;
            $error("wr_req dropped or wr_addr changed before wr_rdy");
        end

    one_channel: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req))
        else begin
            fail_count++;
            $error("rd_req and wr_req high together");
        end

    no_idle_done: assert property (@(posedge clk) disable iff (rst) data_ok |-> state != idle)
        else begin
            fail_count++;
            $error("data_ok raised while the controller is idle");
        end

endmodule

bind cache_top cache_props props_i (
    .clk, .rst, .rd_req, .rd_addr, .rd_rdy, .wr_req, .wr_addr, .wr_rdy, .data_ok,
    .state (ctrl_i.state)
);

/* test/cache_tb.sv */
`timescale 1ns/10ps

module cache_tb import cache_pkg::*; ();

    localparam int mem_words  = 16384;     // 64 KiB
    localparam int total_reqs = 421;
    localparam int miss_len   = 40;        // write-back plus refill under stalls
    localparam int max_cycles = 20 * total_reqs * miss_len;

    logic clk, rst, valid, op, addr_ok, data_ok;
    logic [index_w-1:0] index;
    logic [tag_w-1:0] tag;
    logic [offset_w-1:0] offset;
    logic [3:0] wstrb;
    logic [31:0] wdata, rdata, rd_addr, ret_data, wr_addr;
    logic rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    logic [num_banks*32-1:0] wr_data;

    logic [31:0] mem [mem_words];          // bridge backing store
    logic [31:0] shadow [mem_words];       // architectural view
    logic [32:0] pend [$];                 // {op, expected word}
    integer seed = 41858;
    int errors, tests, failed_tests, cycles, rd_count, wb_count, test_err0;
    logic rd_busy;
    logic [13:0] rd_base;
    logic [1:0] rd_beat;
    logic [31:0] req_line;                 // line of the last accepted request
    logic [31:0] rnd_op [400];

    cache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] init_word(input int w);
        return (w * 32'h9e37_79b1) ^ 32'h5a5a_0000 ^ w;
    endfunction

    // expected load result from the shadow memory
    function automatic logic [31:0] ref_load(input logic [31:0] a);
        return shadow[a[15:2]];
    endfunction

    task automatic apply_store(input logic [31:0] a, input logic [3:0] s, input logic [31:0] d);
        for (int i = 0; i < 4; i++) begin
            if (s[i]) shadow[a[15:2]][8*i +: 8] = d[8*i +: 8];
        end
    endtask

    task automatic issue(input logic o, input logic [tag_w-1:0] t, input logic [index_w-1:0] i,
                         input logic [offset_w-1:0] off, input logic [3:0] s,
                         input logic [31:0] d);
        logic [31:0] a;
        logic done;
        a = {t, i, off};
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            valid = 1'b1;
            op = o;
            tag = t;
            index = i;
            offset = off;
            wstrb = s;
            wdata = d;
            #1;
            done = addr_ok;
            @(posedge clk);
        end
        req_line = {t, i, 4'h0};
        pend.push_back({o, ref_load(a)});   // loads see every earlier store
        if (o) apply_store(a, s, d);
    endtask

    task automatic drain();
        @(negedge clk);
        valid = 1'b0;
        while (pend.size() != 0 || dut_i.ctrl_i.state != idle) @(posedge clk);
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors != test_err0) failed_tests++;
        $display("test %0d %s: %s", tests, name, (errors == test_err0) ? "ok" : "errors seen");
        test_err0 = errors;
    endtask

    // bridge outputs, random stalls between beats
    always @(negedge clk) begin
        if (!rst) begin
            rd_rdy = ($random(seed) & 3) != 0;
            wr_rdy = ($random(seed) & 3) != 0;
            ret_valid = rd_busy && (($random(seed) & 3) != 0);
            ret_data = mem[{rd_base[13:2], rd_beat}];
            ret_last = (rd_beat == 2'd3);
        end
    end

    // handshakes, compare and timeout
    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
        if (data_ok) begin
            assert (pend.size() != 0) else begin
                $display("error at %0t: data_ok with no request outstanding", $time);
                errors++;
            end
            if (pend.size() != 0) begin
                if (!pend[0][32]) begin
                    assert (rdata == pend[0][31:0]) else begin
                        $display("MISMATCH at %0t: load got %h, expected %h",
                                 $time, rdata, pend[0][31:0]);
                        errors++;
                    end
                end
                void'(pend.pop_front());
            end
        end
        if (ret_valid && rd_busy) begin
            rd_beat <= rd_beat + 2'd1;
            if (ret_last) rd_busy <= 1'b0;
        end
        if (rd_req && rd_rdy) begin
            assert (rd_addr == req_line) else begin
                $display("MISMATCH at %0t: read address %h, expected line %h",
                         $time, rd_addr, req_line);
                errors++;
            end
            rd_count++;
            rd_busy <= 1'b1;
            rd_base <= rd_addr[15:2];
            rd_beat <= 2'd0;
        end
        if (wr_req && wr_rdy) begin
            wb_count++;
            // victim sits in the missing set under another tag
            assert (wr_addr[11:0] == {req_line[11:4], 4'h0}
                    && wr_addr[31:12] != req_line[31:12]) else begin
                $display("MISMATCH at %0t: write-back address %h, miss was to line %h",
                         $time, wr_addr, req_line);
                errors++;
            end
            for (int k = 0; k < 4; k++) begin
                assert (wr_data[32*k +: 32] == shadow[wr_addr[15:4]*4 + k]) else begin
                    $display("MISMATCH at %0t: write-back %h word %0d got %h, expected %h",
                             $time, wr_addr, k, wr_data[32*k +: 32],
                             shadow[wr_addr[15:4]*4 + k]);
                    errors++;
                end
                mem[wr_addr[15:4]*4 + k] = wr_data[32*k +: 32];
            end
        end
    end

    initial begin
        int rd0, wb0;
        for (int w = 0; w < mem_words; w++) begin
            mem[w] = init_word(w);
            shadow[w] = init_word(w);
        end
        // random ops drawn before the bridge starts using the seed
        for (int n = 0; n < 400; n++) rnd_op[n] = $random(seed);
        {valid, op, tag, index, offset, wstrb, wdata} = '0;
        {rd_rdy, wr_rdy, ret_valid, ret_last, ret_data} = '0;
        rd_busy = 1'b0;
        rd_base = '0;
        rd_beat = '0;
        req_line = '0;
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        rd0 = rd_count;
        for (int n = 1; n <= 4; n++) issue(0, 20'd1, 8'(n * 16), 4'(n * 4 - 4), 4'h0, 0);
        drain();
        assert (rd_count - rd0 == 4) else begin
            $display("MISMATCH at %0t: %0d line reads on cold misses, expected 4",
                     $time, rd_count - rd0);
            errors++;
        end
        close_test("cold misses");

        rd0 = rd_count;
        for (int n = 1; n <= 4; n++) issue(0, 20'd1, 8'(n * 16), 4'(n * 4 - 4), 4'h0, 0);
        drain();
        assert (rd_count == rd0) else begin
            $display("MISMATCH at %0t: repeated hits issued %0d line reads, expected 0",
                     $time, rd_count - rd0);
            errors++;
        end
        close_test("repeated hits");

        issue(1, 20'd1, 8'h10, 4'h4, 4'b0110, 32'hdead_beef);
        issue(0, 20'd1, 8'h10, 4'h4, 4'h0, 0);
        issue(1, 20'd1, 8'h20, 4'h8, 4'b1001, 32'h1234_5678);
        issue(0, 20'd1, 8'h20, 4'h8, 4'h0, 0);
        drain();
        close_test("store then load");

        wb0 = wb_count;
        for (int t = 2; t <= 4; t++) issue(1, 20'(t), 8'h05, 4'h0, 4'hf, 32'(t * 32'h0101_0101));
        for (int t = 2; t <= 4; t++) issue(0, 20'(t), 8'h05, 4'h0, 4'h0, 0);
        drain();
        assert (wb_count != wb0) else begin
            $display("error: three tags in one set caused no write-back");
            errors++;
        end
        close_test("eviction");

        issue(1, 20'd7, 8'h09, 4'h4, 4'b0011, 32'hcafe_f00d);
        issue(0, 20'd7, 8'h09, 4'h8, 4'h0, 0);
        issue(0, 20'd7, 8'h09, 4'h4, 4'h0, 0);
        drain();
        close_test("store miss");

        for (int n = 0; n < 400; n++) begin
            issue(rnd_op[n][0], 20'(rnd_op[n][7:5] % 6 + 1), 8'(rnd_op[n][10:8]),
                  {rnd_op[n][12:11], 2'b00}, rnd_op[n][16:13] | 4'h1, rnd_op[n] ^ 32'(n));
        end
        drain();
        close_test("random mix");

        errors += dut_i.props_i.fail_count;   // bound handshake checks
        $display("tests %0d, failed %0d, errors %0d, line reads %0d, write-backs %0d",
                 tests, failed_tests, errors, rd_count, wb_count);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
verilog/cache_pkg.sv
verilog/cache_sram.sv
verilog/cache_store_buffer.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
test/cache_props.sv
test/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_sram.sv
  - verilog/cache_store_buffer.sv
  - verilog/cache_ctrl.sv
  - verilog/cache_top.sv
  - target: test
    files:
      - test/cache_props.sv
      - test/cache_tb.sv
